/* hw/arb_pkg.sv */
// Shared sizes and command opcodes for the four-master register bank
`default_nettype none

package arb_pkg;

  // Number of masters sharing the register bank
  localparam int NUM_REQ = 4;

  // Width of a binary master index
  localparam int IDX_W = 2;

  // Register address width, 16 registers in the bank
  localparam int ADDR_W = 4;

  // Register data width
  localparam int DATA_W = 8;

  // Command carried with each request
  typedef enum logic [0:0] {
    OP_READ  = 1'b0,  // Return register contents to the master
    OP_WRITE = 1'b1   // Update one register
  } cmd_op_e;

endpackage

`default_nettype wire

/* hw/priority_arb.sv */
// Fixed priority arbiter where the lowest requesting index wins with a one-hot grant
`timescale 1ns/1ps
`default_nettype none

module priority_arb (
  input  logic [arb_pkg::NUM_REQ-1:0] req_i,  // Request vector, bit 0 highest priority
  output logic [arb_pkg::NUM_REQ-1:0] gnt_o   // One-hot grant, all zero when idle
);

  import arb_pkg::*;

  logic [NUM_REQ-1:0] lower_req;  // Bit i set when any index below i requests

  // Ripple the request OR from index 0 upward
  always_comb begin
    lower_req = '0;
    for (int i = 1; i < NUM_REQ; i++) begin
      lower_req[i] = lower_req[i-1] | req_i[i-1];  // Carry any earlier request
    end
  end

  // A bit survives only if nothing below it requests
  assign gnt_o = req_i & ~lower_req;  // Lowest set bit only

endmodule

`default_nettype wire

/* hw/rr_arbiter.sv */
// Masked round robin arbiter with registered one-hot grant, index, strobe and group release
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        enable_i,       // Arbitration enable
  input  logic [arb_pkg::NUM_REQ-1:0] req_i,          // Level requests
  output logic [arb_pkg::NUM_REQ-1:0] gnt_o,          // Registered one-hot grant
  output logic [arb_pkg::IDX_W-1:0]   gnt_idx_o,      // Binary index of the winner
  output logic                        gnt_valid_o,    // One cycle per new grant
  output logic                        grp_release_o   // Grant came from the raw path
);

  import arb_pkg::*;

  logic [NUM_REQ-1:0] mask_q;         // Indices above the last winner
  logic [NUM_REQ-1:0] gnt_q;          // Grant issued on the last enabled edge
  logic               gnt_valid_q;    // New grant strobe
  logic               grp_release_q;  // Round wrap flag

  logic [NUM_REQ-1:0] mask_req;       // Requests still eligible in this round
  logic [NUM_REQ-1:0] mask_gnt;       // Winner among the masked requests
  logic [NUM_REQ-1:0] raw_gnt;        // Winner among all requests
  logic [NUM_REQ-1:0] sel_gnt;        // Grant to be loaded
  logic [NUM_REQ-1:0] nxt_mask;       // Mask following sel_gnt
  logic               masked_hit;     // Some masked request present
  logic               any_req;        // Some request present
  logic [IDX_W-1:0]   gnt_idx;        // Encoded registered grant

  assign mask_req   = req_i & mask_q;
  assign masked_hit = |mask_req;
  assign any_req    = |req_i;

  priority_arb masked_arb (
    .req_i (mask_req),
    .gnt_o (mask_gnt)
  );

  priority_arb raw_arb (
    .req_i (req_i),
    .gnt_o (raw_gnt)
  );

  // Masked path first, fall back to raw on a wrap
  assign sel_gnt = masked_hit ? mask_gnt : raw_gnt;

  // Next mask from the grant being issued now, so bits above the winner
  always_comb begin
    nxt_mask = '0;
    for (int i = 1; i < NUM_REQ; i++) begin
      nxt_mask[i] = nxt_mask[i-1] | sel_gnt[i-1];  // Set once the winner is passed
    end
  end

  // One-hot to binary, zero when no grant is held
  always_comb begin
    gnt_idx = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (gnt_q[i]) begin
        gnt_idx = gnt_idx | IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mask_q        <= '1;  // First grant comes from the masked path
      gnt_q         <= '0;
      gnt_valid_q   <= 1'b0;
      grp_release_q <= 1'b0;
    end else begin
      gnt_valid_q   <= 1'b0;  // Strobes default low
      grp_release_q <= 1'b0;
      if (enable_i) begin
        if (any_req) begin
          gnt_q         <= sel_gnt;
          mask_q        <= nxt_mask;
          gnt_valid_q   <= 1'b1;
          grp_release_q <= ~masked_hit;  // Raw winner marks a new round
        end else begin
          gnt_q <= '0;  // Idle cycle, mask held
        end
      end
      // Enable low holds grant and mask
    end
  end

  assign gnt_o         = gnt_q;
  assign gnt_idx_o     = gnt_idx;
  assign gnt_valid_o   = gnt_valid_q;
  assign grp_release_o = grp_release_q;

endmodule

`default_nettype wire

/* hw/shared_regfile.sv */
// Register bank that executes the granted master's read or write command
`timescale 1ns/1ps
`default_nettype none

module shared_regfile (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       gnt_valid_i,  // New grant strobe
  input  logic [arb_pkg::IDX_W-1:0]                  gnt_idx_i,    // Granted master
  input  arb_pkg::cmd_op_e [arb_pkg::NUM_REQ-1:0]    op_i,         // Opcode per master
  input  logic [arb_pkg::NUM_REQ*arb_pkg::ADDR_W-1:0] addr_i,      // Flattened addresses
  input  logic [arb_pkg::NUM_REQ*arb_pkg::DATA_W-1:0] wdata_i,     // Flattened write data
  output logic [arb_pkg::DATA_W-1:0]                 rdata_o,      // Read data
  output logic                                       rd_valid_o,   // Read done strobe
  output logic [arb_pkg::IDX_W-1:0]                  rd_master_o   // Master that read
);

  import arb_pkg::*;

  // Per-master views of the flattened command buses
  logic [ADDR_W-1:0] cmd_addr  [NUM_REQ];
  logic [DATA_W-1:0] cmd_wdata [NUM_REQ];

  // Command of the granted master
  cmd_op_e           sel_op;
  logic [ADDR_W-1:0] sel_addr;
  logic [DATA_W-1:0] sel_wdata;

  logic do_write;  // Granted write this cycle
  logic do_read;   // Granted read this cycle

  // Register storage, 2**ADDR_W entries
  logic [DATA_W-1:0] regs_q [2**ADDR_W];

  // Read result registers
  logic [DATA_W-1:0] rdata_q;
  logic              rd_valid_q;
  logic [IDX_W-1:0]  rd_master_q;

  // Slice the flat vectors, master i at slot i
  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      cmd_addr[i]  = addr_i[i*ADDR_W +: ADDR_W];
      cmd_wdata[i] = wdata_i[i*DATA_W +: DATA_W];
    end
  end

  // Mux by grant index, commands are stable while requested
  assign sel_op    = op_i[gnt_idx_i];
  assign sel_addr  = cmd_addr[gnt_idx_i];
  assign sel_wdata = cmd_wdata[gnt_idx_i];

  // Act only on the cycle after a fresh grant
  assign do_write = gnt_valid_i & (sel_op == OP_WRITE);
  assign do_read  = gnt_valid_i & (sel_op == OP_READ);

  // Bank clears to zero, one write per cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (do_write) begin
      regs_q[sel_addr] <= sel_wdata;  // Lands two edges after the request sample
    end
  end

  // Read strobe, one cycle per completed read
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= do_read;
    end
  end

  // Read data and tag, qualified by rd_valid_o
  always_ff @(posedge clk) begin
    if (do_read) begin
      rdata_q     <= regs_q[sel_addr];
      rd_master_q <= gnt_idx_i;  // Tag with the requesting master
    end
  end

  assign rdata_o     = rdata_q;
  assign rd_valid_o  = rd_valid_q;
  assign rd_master_o = rd_master_q;

endmodule

`default_nettype wire

/* hw/arb_subsys_top.sv */
// Shared register bank subsystem, round robin arbiter feeding the register bank
`timescale 1ns/1ps
`default_nettype none

module arb_subsys_top (
  input  logic                                       clk,
  input  logic                                       reset,          // Async, active high
  input  logic                                       enable_i,       // Gates arbitration
  input  logic [arb_pkg::NUM_REQ-1:0]                req_i,          // Level requests
  input  arb_pkg::cmd_op_e [arb_pkg::NUM_REQ-1:0]    op_i,           // Opcode per master
  input  logic [arb_pkg::NUM_REQ*arb_pkg::ADDR_W-1:0] addr_i,        // Address per master
  input  logic [arb_pkg::NUM_REQ*arb_pkg::DATA_W-1:0] wdata_i,       // Write data per master
  output logic [arb_pkg::NUM_REQ-1:0]                gnt_o,          // One-hot grant
  output logic                                       grp_release_o,  // Round wrap marker
  output logic [arb_pkg::DATA_W-1:0]                 rdata_o,        // Read data
  output logic                                       rd_valid_o,     // Read done strobe
  output logic [arb_pkg::IDX_W-1:0]                  rd_master_o     // Reader index
);

  import arb_pkg::*;

  // Arbiter to bank
  logic [IDX_W-1:0] gnt_idx;    // Winner index from registered grant
  logic             gnt_valid;  // High one cycle per new grant

  // Picks one master per enabled cycle
  rr_arbiter arb_inst (
    .clk           (clk),
    .reset         (reset),
    .enable_i      (enable_i),
    .req_i         (req_i),
    .gnt_o         (gnt_o),
    .gnt_idx_o     (gnt_idx),
    .gnt_valid_o   (gnt_valid),
    .grp_release_o (grp_release_o)
  );

  // Executes the winner's command one edge later
  shared_regfile regfile_inst (
    .clk         (clk),
    .reset       (reset),
    .gnt_valid_i (gnt_valid),
    .gnt_idx_i   (gnt_idx),
    .op_i        (op_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .rdata_o     (rdata_o),
    .rd_valid_o  (rd_valid_o),
    .rd_master_o (rd_master_o)
  );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
// Free running testbench clock source with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o  // Testbench clock
);

  localparam int PERIOD_NS = 4;  // Full period

  // Starts low, so the first rising edge is at half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;  // Toggle every half period
    end
  end

endmodule

`default_nettype wire

/* tests/tb_arb_subsys.sv */
// Testbench for the shared register bank subsystem with a cycle model and directed and random tests
`timescale 1ns/1ps
`default_nettype none

module tb_arb_subsys;

  import arb_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int RAND_CYCLES   = 200;
  localparam int TEST_CYCLES   = 5 * RESET_CYCLES + 44 + RAND_CYCLES;  // Resets, directed, random
  localparam int MARGIN_CYCLES = 100;

  logic                      clk;
  logic                      reset;
  logic                      enable;
  logic [NUM_REQ-1:0]        req;
  cmd_op_e [NUM_REQ-1:0]     op;
  logic [NUM_REQ*ADDR_W-1:0] addr;
  logic [NUM_REQ*DATA_W-1:0] wdata;
  logic [NUM_REQ-1:0]        gnt;
  logic                      grp_release;
  logic [DATA_W-1:0]         rdata;
  logic                      rd_valid;
  logic [IDX_W-1:0]          rd_master;

  int     errors;
  int     checks;
  integer seed;  // Random stream state

  // Cycle model of arbiter and bank
  logic [NUM_REQ-1:0] m_mask;       // Indices above the last winner
  logic [NUM_REQ-1:0] m_gnt;        // Expected registered grant
  logic               m_valid;      // Expected new grant strobe
  logic               m_release;    // Expected group release
  logic [IDX_W-1:0]   m_idx;        // Winner index
  logic [DATA_W-1:0]  m_regs [2**ADDR_W];
  logic [DATA_W-1:0]  m_rdata;
  logic               m_rd_valid;
  logic [IDX_W-1:0]   m_rd_master;

  tb_clock clock_inst (
    .clk_o (clk)
  );

  arb_subsys_top arb_subsys_top_inst (
    .clk           (clk),
    .reset         (reset),
    .enable_i      (enable),
    .req_i         (req),
    .op_i          (op),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .gnt_o         (gnt),
    .grp_release_o (grp_release),
    .rdata_o       (rdata),
    .rd_valid_o    (rd_valid),
    .rd_master_o   (rd_master)
  );

  task automatic check_gnt(input logic [NUM_REQ-1:0] got, input logic [NUM_REQ-1:0] exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic model_reset();
    m_mask     = '1;  // Whole first round eligible
    m_gnt      = '0;
    m_valid    = 1'b0;
    m_release  = 1'b0;
    m_idx      = '0;
    m_rd_valid = 1'b0;
    for (int i = 0; i < 2**ADDR_W; i++) begin
      m_regs[i] = '0;
    end
  endtask

  // One clock edge of the model with the inputs sampled on that edge
  task automatic model_update();
    int k;
    int win;
    logic [ADDR_W-1:0] a;
    k = m_idx;
    m_rd_valid = 1'b0;
    if (m_valid) begin  // Bank acts on the edge after a grant strobe
      a = addr[k*ADDR_W +: ADDR_W];
      if (op[k] == OP_WRITE) begin
        m_regs[a] = wdata[k*DATA_W +: DATA_W];
      end else begin
        m_rd_valid  = 1'b1;
        m_rdata     = m_regs[a];
        m_rd_master = m_idx;
      end
    end
    m_valid   = 1'b0;
    m_release = 1'b0;
    if (enable && (req == '0)) begin
      m_gnt = '0;  // Idle edge clears the grant and keeps the mask
    end else if (enable) begin
      win = -1;
      for (int i = 0; i < NUM_REQ; i++) begin
        if (win < 0 && req[i] && m_mask[i]) begin
          win = i;  // Lowest masked request
        end
      end
      if (win < 0) begin
        m_release = 1'b1;  // Wrap to the raw requests
        for (int i = 0; i < NUM_REQ; i++) begin
          if (win < 0 && req[i]) begin
            win = i;
          end
        end
      end
      m_gnt      = '0;
      m_gnt[win] = 1'b1;
      m_idx      = IDX_W'(win);
      m_valid    = 1'b1;
      for (int i = 0; i < NUM_REQ; i++) begin
        m_mask[i] = (i > win);  // Only indices above the winner stay eligible
      end
    end
  endtask

  task automatic compare_model();
    check_gnt(gnt, m_gnt, "model grant");
    check_bit(grp_release, m_release, "model group release");
    check_bit(rd_valid, m_rd_valid, "model read valid");
    if (m_rd_valid) begin
      check_data(rdata, m_rdata, "model read data");
      check_idx(rd_master, m_rd_master, "model read master");
    end
  endtask

  // Model follows the rising edge and compares on the falling edge
  task automatic step();
    @(posedge clk);
    model_update();
    @(negedge clk);
    compare_model();
  endtask

  task automatic apply_reset();
    reset  = 1'b1;
    enable = 1'b0;
    req    = '0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;  // Released on a falling edge
  endtask

  // Single master command with the request dropped once the grant is seen
  task automatic bank_access(input int idx, input cmd_op_e cmd, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d);
    req                           = '0;
    req[idx]                      = 1'b1;
    op[idx]                       = cmd;
    addr[idx*ADDR_W +: ADDR_W]    = a;
    wdata[idx*DATA_W +: DATA_W]   = d;
    step();  // Request sampled, grant registered
    req = '0;
    step();  // Bank acts while the command is still stable
  endtask

  task automatic after_reset();
    apply_reset();
    check_gnt(gnt, '0, "grant after reset");
    check_bit(grp_release, 1'b0, "release after reset");
    check_bit(rd_valid, 1'b0, "read valid after reset");
    enable = 1'b1;
    req    = '1;
    step();
    check_gnt(gnt, NUM_REQ'(1), "first grant");
    check_bit(grp_release, 1'b0, "release on first grant");
    req = '0;
    step();
  endtask

  task automatic full_rotation();
    int   order [6] = '{0, 1, 2, 3, 0, 1};
    logic wrap  [6] = '{0, 0, 0, 0, 1, 0};  // Release only on the second 0
    apply_reset();
    enable = 1'b1;
    req    = '1;
    for (int n = 0; n < 6; n++) begin
      step();
      check_gnt(gnt, NUM_REQ'(1) << order[n], "rotation grant");
      check_bit(grp_release, wrap[n], "rotation release");
    end
    req = '0;
    step();
  endtask

  task automatic sparse_requests();
    int   order [8] = '{1, 3, 1, 3, 1, 3, 1, 3};
    logic wrap  [8] = '{0, 0, 1, 0, 1, 0, 1, 0};
    apply_reset();
    enable = 1'b1;
    req    = 4'b1010;
    for (int n = 0; n < 8; n++) begin
      if (n == 4) begin
        req[2] = 1'b1;  // Master 2 loses to master 1 on the wrap
      end
      if (n == 5) begin
        req[2] = 1'b0;  // Withdrawn before it could win
      end
      step();
      check_gnt(gnt, NUM_REQ'(1) << order[n], "sparse grant");
      check_bit(grp_release, wrap[n], "sparse release");
    end
    req = '0;
    step();
  endtask

  task automatic enable_hold();
    logic [NUM_REQ-1:0] held;
    apply_reset();
    for (int i = 0; i < NUM_REQ; i++) begin
      op[i]                    = OP_READ;  // Reads make any stray bank strobe visible
      addr[i*ADDR_W +: ADDR_W] = ADDR_W'(i + 8);
    end
    enable = 1'b1;
    req    = '1;
    step();
    step();
    held = gnt;
    check_gnt(held, NUM_REQ'(2), "grant before hold");
    enable = 1'b0;
    for (int n = 0; n < 3; n++) begin
      step();
      check_gnt(gnt, held, "held grant");
      check_bit(grp_release, 1'b0, "release while disabled");
      check_bit(rd_valid, (n == 0), "read while disabled");  // Only the read granted before
    end
    enable = 1'b1;
    step();
    check_gnt(gnt, NUM_REQ'(4), "grant after hold");  // Continues from held mask
    step();
    check_gnt(gnt, NUM_REQ'(8), "second grant after hold");
    req = '0;
    step();
  endtask

  task automatic write_then_read();
    logic [DATA_W-1:0] stored [NUM_REQ];
    int src;
    apply_reset();
    enable = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      stored[i] = DATA_W'(8'h3c + 37 * i);
      bank_access(i, OP_WRITE, ADDR_W'(4 * i + 3), stored[i]);
      check_bit(rd_valid, 1'b0, "read strobe on write");
    end
    for (int i = 0; i < NUM_REQ; i++) begin
      src = (i + 1) % NUM_REQ;  // Read the neighbour's register
      bank_access(i, OP_READ, ADDR_W'(4 * src + 3), '0);
      check_bit(rd_valid, 1'b1, "read strobe");
      check_data(rdata, stored[src], "read back data");
      check_idx(rd_master, IDX_W'(i), "read master tag");
    end
  endtask

  // Masters hold requests until granted and change commands only while idle
  task automatic random_traffic();
    for (int n = 0; n < RAND_CYCLES; n++) begin
      enable = (($random(seed) & 7) != 0);  // Mostly enabled
      for (int i = 0; i < NUM_REQ; i++) begin
        if (m_gnt[i]) begin
          req[i] = 1'b0;  // Command kept for the bank edge after the grant
        end else if (!req[i] && (($random(seed) & 1) != 0)) begin
          req[i]                    = 1'b1;
          op[i]                     = cmd_op_e'($random(seed) & 1);
          addr[i*ADDR_W +: ADDR_W]  = ADDR_W'($random(seed));
          wdata[i*DATA_W +: DATA_W] = DATA_W'($random(seed));
        end
      end
      step();
    end
    req    = '0;
    enable = 1'b1;
    step();  // Drain the last command
    step();
  endtask

  initial begin
    errors = 0;
    checks = 0;
    seed   = 88;
    reset  = 1'b1;
    enable = 1'b0;
    req    = '0;
    addr   = '0;
    wdata  = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      op[i] = OP_READ;
    end
    model_reset();
    after_reset();
    full_rotation();
    sparse_requests();
    enable_hold();
    write_then_read();
    random_traffic();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from the test length
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
    $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/arb_pkg.sv
hw/priority_arb.sv
hw/rr_arbiter.sv
hw/shared_regfile.sv
hw/arb_subsys_top.sv
tests/tb_clock.sv
tests/tb_arb_subsys.sv

/* Bender.yml */
package:
  name: arb_subsys

sources:
  # Design sources in compile order
  - files:
      - hw/arb_pkg.sv
      - hw/priority_arb.sv
      - hw/rr_arbiter.sv
      - hw/shared_regfile.sv
      - hw/arb_subsys_top.sv

  # Testbench, top module tb_arb_subsys
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_arb_subsys.sv
